//--- bench/udp_echo_assert.sv
//////////////////////////////
// Handshake rules on the echo core outputs
// Bound into every udp_echo_top instance
//////////////////////////////

`timescale 1ns/1ps

module udp_echo_assert (
    input logic                      clk,
    input logic                      rst,
    input net_types_pkg::udp_hdr_t   out_hdr,
    input logic                      out_hdr_valid,
    input logic                      out_hdr_ready,
    input net_types_pkg::byte_beat_t out_beat,
    input logic                      out_valid,
    input logic                      out_ready,
    input logic                      in_ready
);

    int fail_count = 0;

    // A waiting header holds until taken
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
        else begin
            $error("out_hdr changed or went away before out_hdr_ready");
            fail_count++;
        end

    beat_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("out_beat changed or went away before out_ready");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk)
        rst |=> !out_hdr_valid && !out_valid && !in_ready)
        else begin
            $error("outputs not idle in the cycle after reset");
            fail_count++;
        end

endmodule

bind udp_echo_top udp_echo_assert assert_inst (
    .clk           (clk),
    .rst           (rst),
    .out_hdr       (out_hdr),
    .out_hdr_valid (out_hdr_valid),
    .out_hdr_ready (out_hdr_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .in_ready      (in_ready)
);

//--- bench/udp_echo_tb.sv
//////////////////////////////
// Testbench for udp_echo_top at default parameters
// Random datagrams from a fixed LFSR seed, model queues
// Outputs sampled on the falling edge
//////////////////////////////

`timescale 1ns/1ps

module udp_echo_tb;

    localparam int NUM_DG  = 40;
    localparam int MAX_LEN = 16;
    // Up to MAX_LEN + 2 input cycles per datagram, output stalls and margin on top
    localparam int TIMEOUT_CYCLES = NUM_DG * (MAX_LEN + 2) * 4 + 120;

    logic                      clk;
    logic                      rst;
    net_types_pkg::udp_hdr_t   in_hdr;
    logic                      in_hdr_valid;
    logic                      in_hdr_ready;
    net_types_pkg::byte_beat_t in_beat;
    logic                      in_valid;
    logic                      in_ready;
    net_types_pkg::udp_hdr_t   out_hdr;
    logic                      out_hdr_valid;
    logic                      out_hdr_ready;
    net_types_pkg::byte_beat_t out_beat;
    logic                      out_valid;
    logic                      out_ready;
    net_types_pkg::byte_t      led;

    // Stimulus, built once before reset
    net_types_pkg::udp_hdr_t   dg_hdr [NUM_DG];
    net_types_pkg::byte_beat_t dg_beats [NUM_DG][MAX_LEN];
    int                        dg_len [NUM_DG];
    logic                      dg_echo [NUM_DG];

    // Model of what must leave the core
    net_types_pkg::udp_hdr_t   exp_hdr [$];
    net_types_pkg::byte_beat_t exp_beat [$];
    net_types_pkg::byte_t      exp_led [$];
    int                        exp_id [$];

    logic [31:0]               lfsr_state;
    logic                      gen_done;
    logic                      led_pending;
    net_types_pkg::byte_t      led_expect;
    net_types_pkg::byte_beat_t beat_expect;
    int                        led_id;
    int                        cycles;
    int                        checks;
    int                        errors;
    int                        hdr_count;
    int                        beat_count;

    udp_echo_top uut (
        .clk           (clk),
        .rst           (rst),
        .in_hdr        (in_hdr),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .led           (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s got %0h expected %0h", name, got, expected);
        end
    endtask

    task automatic build_datagrams();
        net_types_pkg::udp_hdr_t h;
        net_types_pkg::udp_hdr_t r;
        for (int d = 0; d < NUM_DG; d++) begin
            h.src_ip   = rand_bits(32);
            h.dst_ip   = rand_bits(32);
            h.src_port = 16'(rand_bits(16));
            dg_echo[d] = next_bit();
            if (dg_echo[d]) begin
                h.dst_port = echo_cfg_pkg::DEFAULT_ECHO_PORT;
            end else begin
                h.dst_port = 16'(rand_bits(16));
                if (h.dst_port == echo_cfg_pkg::DEFAULT_ECHO_PORT) begin
                    h.dst_port ^= 16'h0001;
                end
            end
            dg_len[d] = int'(rand_bits(4)) + 1;
            // UDP length counts the 8 header bytes
            h.length  = 16'(dg_len[d] + 8);
            dg_hdr[d] = h;
            for (int i = 0; i < dg_len[d]; i++) begin
                dg_beats[d][i].data = 8'(rand_bits(8));
                dg_beats[d][i].last = (i == dg_len[d] - 1);
                dg_beats[d][i].user = 1'b0;
                if (i == dg_len[d] - 1) begin
                    dg_beats[d][i].user = (rand_bits(2) == 32'd0);
                end
            end
            if (dg_echo[d]) begin
                // Swap rule, local address as source
                r.src_ip   = echo_cfg_pkg::DEFAULT_LOCAL_IP;
                r.dst_ip   = h.src_ip;
                r.src_port = h.dst_port;
                r.dst_port = h.src_port;
                r.length   = h.length;
                exp_hdr.push_back(r);
                for (int i = 0; i < dg_len[d]; i++) begin
                    exp_beat.push_back(dg_beats[d][i]);
                end
                exp_led.push_back(dg_beats[d][0].data);
                exp_id.push_back(d);
            end
        end
    endtask

    task automatic send_datagram(input int d);
        logic taken;
        in_hdr       = dg_hdr[d];
        in_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            taken = in_hdr_ready;
            @(posedge clk);
            #5;
        end while (!taken);
        in_hdr_valid = 1'b0;
        for (int i = 0; i < dg_len[d]; i++) begin
            in_beat  = dg_beats[d][i];
            in_valid = 1'b1;
            do begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #5;
            end while (!taken);
        end
        in_valid = 1'b0;
        if (!dg_echo[d]) begin
            $display("datagram %0d dropped, %0d beats accepted", d, dg_len[d]);
        end
    endtask

    // Output back-pressure, low on about 3 of 8 cycles
    always @(posedge clk) begin
        if (gen_done && !rst) begin
            #5;
            out_hdr_ready = (rand_bits(3) >= 32'd3);
            out_ready     = (rand_bits(3) >= 32'd3);
        end
    end

    // Handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (led_pending) begin
                check("led", 128'(led), 128'(led_expect));
                $display("datagram %0d echoed, led %0h", led_id, led);
                led_pending = 1'b0;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                hdr_count++;
                if (exp_hdr.size() == 0) begin
                    errors++;
                    $display("A reply header came out with no echoed datagram waiting for it");
                end else begin
                    check("out_hdr", 128'(out_hdr), 128'(exp_hdr.pop_front()));
                end
            end
            if (out_valid && out_ready) begin
                beat_count++;
                if (exp_beat.size() == 0) begin
                    errors++;
                    $display("A payload beat came out with no echoed byte waiting for it");
                end else begin
                    beat_expect = exp_beat.pop_front();
                    check("out_beat", 128'(out_beat), 128'(beat_expect));
                    if (beat_expect.last) begin
                        led_expect  = exp_led.pop_front();
                        led_id      = exp_id.pop_front();
                        led_pending = 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, replies still outstanding", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        in_hdr        = '0;
        in_hdr_valid  = 1'b0;
        in_beat       = '0;
        in_valid      = 1'b0;
        out_hdr_ready = 1'b0;
        out_ready     = 1'b0;
        lfsr_state    = 32'hef9c_f9a5;
        gen_done      = 1'b0;
        led_pending   = 1'b0;
        led_expect    = '0;
        led_id        = 0;
        cycles        = 0;
        checks        = 0;
        errors        = 0;
        hdr_count     = 0;
        beat_count    = 0;
        build_datagrams();
        gen_done = 1'b1;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        check("out_hdr_valid", 128'(out_hdr_valid), 128'(0));
        check("out_valid", 128'(out_valid), 128'(0));
        check("led", 128'(led), 128'(0));
        check("in_hdr_ready", 128'(in_hdr_ready), 128'(0));
        check("in_ready", 128'(in_ready), 128'(0));
        $display("reset test done, outputs idle");
        @(posedge clk);
        #5;
        for (int d = 0; d < NUM_DG; d++) begin
            send_datagram(d);
        end
        while (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (uut.assert_inst.fail_count != 0) begin
            errors++;
            $display("Handshake assertions failed %0d times", uut.assert_inst.fail_count);
        end
        $display("tests %0d, checks %0d, errors %0d, headers %0d, beats %0d",
                 NUM_DG + 1, checks, errors, hdr_count, beat_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- common/echo_cfg_pkg.sv
//////////////////////////////
// Default settings of the echo core
// The top level takes these as its parameter defaults
//////////////////////////////

package echo_cfg_pkg;

    // Datagrams to this port are echoed, all others dropped
    localparam net_types_pkg::udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // Source address of every reply
    localparam net_types_pkg::ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Payload FIFO entries, power of two
    localparam int DEFAULT_FIFO_DEPTH = 64;

endpackage

//--- common/net_types_pkg.sv
//////////////////////////////
// Field widths and bundles for parsed UDP datagrams
// Header fields are plain numbers, no checksum carried
// A payload is one or more byte beats ending on last
//////////////////////////////

package net_types_pkg;

    // Widths that carry a meaning on the wire
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  byte_t;

    // One parsed UDP header, 112 bits
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } udp_hdr_t;

    // One payload byte with its framing flags
    // user marks a bad frame and is never touched by the core
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } byte_beat_t;

endpackage

//--- hdl/payload_fifo.sv
//////////////////////////////
// Byte-stream FIFO with a registered output
// Beats may leave before their datagram is complete
// Holds FIFO_DEPTH beats plus one in the output register
//////////////////////////////

`timescale 1ns/1ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  net_types_pkg::byte_beat_t  fifo_in,
    input  logic                       fifo_in_valid,
    output logic                       fifo_in_ready,
    output net_types_pkg::byte_beat_t  fifo_out,
    output logic                       fifo_out_valid,
    input  logic                       fifo_out_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    net_types_pkg::byte_beat_t mem [FIFO_DEPTH];
    net_types_pkg::byte_beat_t out_reg;
    logic                      out_full;
    // Extra top bit tells full from empty
    logic [AW:0]               wr_ptr;
    logic [AW:0]               rd_ptr;
    logic                      mem_empty;
    logic                      mem_full;
    logic                      wr_en;
    logic                      load_out;
    logic                      bypass;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign fifo_in_ready = !mem_full;
    assign wr_en         = fifo_in_valid && fifo_in_ready;
    assign load_out      = !out_full || fifo_out_ready;
    // Empty memory, so a new beat goes straight to the output register
    assign bypass        = load_out && mem_empty;

    always_ff @(posedge clk) begin
        if (wr_en && !bypass) begin
            mem[wr_ptr[AW-1:0]] <= fifo_in;
        end
        if (load_out) begin
            out_reg <= mem_empty ? fifo_in : mem[rd_ptr[AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            out_full <= 1'b0;
        end else begin
            if (wr_en && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                out_full <= !mem_empty || wr_en;
                if (!mem_empty) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    assign fifo_out       = out_reg;
    assign fifo_out_valid = out_full;

endmodule

//--- hdl/udp_echo_filter.sv
//////////////////////////////
// Per-datagram echo decision, made once on the header
// Payload is routed to the FIFO or swallowed until last
// All outputs combinational, zero-cycle latency
//////////////////////////////

`timescale 1ns/1ps

module udp_echo_filter #(
    parameter net_types_pkg::udp_port_t ECHO_PORT = 16'd1234,
    parameter net_types_pkg::ip_addr_t  LOCAL_IP  = 32'hc0a8_0180
) (
    input  logic                       clk,
    input  logic                       rst,
    input  net_types_pkg::udp_hdr_t    in_hdr,
    input  logic                       in_hdr_valid,
    output logic                       in_hdr_ready,
    input  net_types_pkg::byte_beat_t  in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,
    output net_types_pkg::udp_hdr_t    reply_hdr,
    output logic                       reply_hdr_valid,
    input  logic                       reply_hdr_ready,
    output net_types_pkg::byte_beat_t  fifo_in,
    output logic                       fifo_in_valid,
    input  logic                       fifo_in_ready
);

    typedef enum logic [1:0] {
        IDLE,
        ECHO,
        DROP
    } state_t;

    state_t state;
    logic   port_match;
    logic   hdr_xfer;
    logic   last_xfer;

    assign port_match = (in_hdr.dst_port == ECHO_PORT);

    // Reply header by the swap rule, length kept
    always_comb begin
        reply_hdr.src_ip   = LOCAL_IP;
        reply_hdr.dst_ip   = in_hdr.src_ip;
        reply_hdr.src_port = in_hdr.dst_port;
        reply_hdr.dst_port = in_hdr.src_port;
        reply_hdr.length   = in_hdr.length;
    end

    // Non-matching headers never wait on the reply side
    assign reply_hdr_valid = (state == IDLE) && in_hdr_valid && port_match;
    assign in_hdr_ready    = (state == IDLE) && in_hdr_valid
                             && (!port_match || reply_hdr_ready);

    assign fifo_in       = in_beat;
    assign fifo_in_valid = (state == ECHO) && in_valid;

    always_comb begin
        case (state)
            ECHO:    in_ready = fifo_in_ready;
            DROP:    in_ready = 1'b1;
            default: in_ready = 1'b0;
        endcase
    end

    assign hdr_xfer  = in_hdr_valid && in_hdr_ready;
    assign last_xfer = in_valid && in_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ECHO : DROP;
                    end
                end
                ECHO, DROP: begin
                    if (last_xfer) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/udp_echo_top.sv
//////////////////////////////
// UDP echo core on an already parsed datagram stream
// Valid/ready on both headers, valid/ready/last on beats
// FIFO_DEPTH must be a power of two, at least 2
//////////////////////////////

`timescale 1ns/1ps

module udp_echo_top #(
    parameter net_types_pkg::udp_port_t ECHO_PORT  = echo_cfg_pkg::DEFAULT_ECHO_PORT,
    parameter net_types_pkg::ip_addr_t  LOCAL_IP   = echo_cfg_pkg::DEFAULT_LOCAL_IP,
    parameter int                       FIFO_DEPTH = echo_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  net_types_pkg::udp_hdr_t    in_hdr,
    input  logic                       in_hdr_valid,
    output logic                       in_hdr_ready,
    input  net_types_pkg::byte_beat_t  in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,
    output net_types_pkg::udp_hdr_t    out_hdr,
    output logic                       out_hdr_valid,
    input  logic                       out_hdr_ready,
    output net_types_pkg::byte_beat_t  out_beat,
    output logic                       out_valid,
    input  logic                       out_ready,
    output net_types_pkg::byte_t       led
);

    // Filter to FIFO
    net_types_pkg::byte_beat_t fifo_in;
    logic                      fifo_in_valid;
    logic                      fifo_in_ready;

    // FIFO to reply stage
    net_types_pkg::byte_beat_t fifo_out;
    logic                      fifo_out_valid;
    logic                      fifo_out_ready;

    // Filter to reply stage
    net_types_pkg::udp_hdr_t   reply_hdr;
    logic                      reply_hdr_valid;
    logic                      reply_hdr_ready;

    udp_echo_filter #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) filter_inst (
        .clk             (clk),
        .rst             (rst),
        .in_hdr          (in_hdr),
        .in_hdr_valid    (in_hdr_valid),
        .in_hdr_ready    (in_hdr_ready),
        .in_beat         (in_beat),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .reply_hdr       (reply_hdr),
        .reply_hdr_valid (reply_hdr_valid),
        .reply_hdr_ready (reply_hdr_ready),
        .fifo_in         (fifo_in),
        .fifo_in_valid   (fifo_in_valid),
        .fifo_in_ready   (fifo_in_ready)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_inst (
        .clk            (clk),
        .rst            (rst),
        .fifo_in        (fifo_in),
        .fifo_in_valid  (fifo_in_valid),
        .fifo_in_ready  (fifo_in_ready),
        .fifo_out       (fifo_out),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_ready (fifo_out_ready)
    );

    udp_reply_stage reply_inst (
        .clk             (clk),
        .rst             (rst),
        .reply_hdr       (reply_hdr),
        .reply_hdr_valid (reply_hdr_valid),
        .reply_hdr_ready (reply_hdr_ready),
        .fifo_out        (fifo_out),
        .fifo_out_valid  (fifo_out_valid),
        .fifo_out_ready  (fifo_out_ready),
        .out_hdr         (out_hdr),
        .out_hdr_valid   (out_hdr_valid),
        .out_hdr_ready   (out_hdr_ready),
        .out_beat        (out_beat),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .led             (led)
    );

endmodule

//--- hdl/udp_reply_stage.sv
//////////////////////////////
// Single-entry reply header register and payload output
// led shows the first byte of the last echoed payload
//////////////////////////////

`timescale 1ns/1ps

module udp_reply_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  net_types_pkg::udp_hdr_t    reply_hdr,
    input  logic                       reply_hdr_valid,
    output logic                       reply_hdr_ready,
    input  net_types_pkg::byte_beat_t  fifo_out,
    input  logic                       fifo_out_valid,
    output logic                       fifo_out_ready,
    output net_types_pkg::udp_hdr_t    out_hdr,
    output logic                       out_hdr_valid,
    input  logic                       out_hdr_ready,
    output net_types_pkg::byte_beat_t  out_beat,
    output logic                       out_valid,
    input  logic                       out_ready,
    output net_types_pkg::byte_t       led
);

    net_types_pkg::udp_hdr_t hdr_reg;
    logic                    hdr_full;
    logic                    hdr_load;
    logic                    beat_xfer;
    // High between the first and the last beat of a payload
    logic                    in_payload;
    net_types_pkg::byte_t    led_reg;

    // Free slot, or the held header leaves this cycle
    assign reply_hdr_ready = !hdr_full || out_hdr_ready;
    assign hdr_load        = reply_hdr_valid && reply_hdr_ready;

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_reg <= reply_hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
        end else if (hdr_load) begin
            hdr_full <= 1'b1;
        end else if (out_hdr_ready) begin
            hdr_full <= 1'b0;
        end
    end

    assign out_hdr       = hdr_reg;
    assign out_hdr_valid = hdr_full;

    // Payload straight from the FIFO
    assign out_beat       = fifo_out;
    assign out_valid      = fifo_out_valid;
    assign fifo_out_ready = out_ready;
    assign beat_xfer      = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_payload <= 1'b0;
            led_reg    <= '0;
        end else if (beat_xfer) begin
            if (!in_payload) begin
                led_reg <= out_beat.data;
            end
            in_payload <= !out_beat.last;
        end
    end

    assign led = led_reg;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the echo core testbench, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module udp_echo_tb -f src.f -o udp_echo_sim \
    && ./obj_dir/udp_echo_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src.f
common/net_types_pkg.sv
common/echo_cfg_pkg.sv
hdl/udp_echo_filter.sv
hdl/payload_fifo.sv
hdl/udp_reply_stage.sv
hdl/udp_echo_top.sv
bench/udp_echo_assert.sv
bench/udp_echo_tb.sv
